/* project.f */
verilog/swrite_regs_pkg.sv
verilog/axil_ctrl.sv
verilog/swrite_reg_bank.sv
verilog/swrite_read_mux.sv
verilog/swrite_unpack_top.sv
test/tb_swrite_unpack.sv

/* test/tb_swrite_unpack.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the SWRITE unpack control registers over AXI4-Lite
// Runs reset, full word, byte strobe, out of range and back-pressure tests
////////////////////////////////////////////////////////////////////////////

module tb_swrite_unpack;

  localparam int DATA_WIDTH  = swrite_regs_pkg::C_DATA_WIDTH;
  localparam int ADDR_WIDTH  = swrite_regs_pkg::C_ADDR_WIDTH;
  localparam int NUM_REGS    = swrite_regs_pkg::C_NUM_REGS;
  localparam int ADDR_LSB    = swrite_regs_pkg::C_ADDR_LSB;
  localparam int NUM_BYTES   = DATA_WIDTH / 8;

  // About 60 transfers of under 10 cycles each, with a tenfold margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic                          S_AXI_ACLK;
  logic                          S_AXI_ARESETN;
  logic [ADDR_WIDTH-1:0]         S_AXI_AWADDR;
  logic                          S_AXI_AWVALID;
  logic                          S_AXI_AWREADY;
  logic [DATA_WIDTH-1:0]         S_AXI_WDATA;
  logic [NUM_BYTES-1:0]          S_AXI_WSTRB;
  logic                          S_AXI_WVALID;
  logic                          S_AXI_WREADY;
  swrite_regs_pkg::resp_t        S_AXI_BRESP;
  logic                          S_AXI_BVALID;
  logic                          S_AXI_BREADY;
  logic [ADDR_WIDTH-1:0]         S_AXI_ARADDR;
  logic                          S_AXI_ARVALID;
  logic                          S_AXI_ARREADY;
  logic [DATA_WIDTH-1:0]         S_AXI_RDATA;
  swrite_regs_pkg::resp_t        S_AXI_RRESP;
  logic                          S_AXI_RVALID;
  logic                          S_AXI_RREADY;
  logic [DATA_WIDTH-1:0]         cmd;
  logic [DATA_WIDTH-1:0]         addr_0;
  logic [DATA_WIDTH-1:0]         addr_1;

  // Expected register contents
  logic [DATA_WIDTH-1:0] model [NUM_REGS];

  string current_test;
  int    word_errors;
  int    resp_errors;
  int    protocol_errors;
  int    cycle_count;

  swrite_unpack_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_REGS   (NUM_REGS)
  ) swrite_unpack_top_inst (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .cmd           (cmd),
    .addr_0        (addr_0),
    .addr_1        (addr_1)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and run limit

  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  always @(posedge S_AXI_ACLK)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_word(input string what, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s %s: expected %h, actual %h", current_test, what, expected, actual);
      word_errors++;
    end
  endtask

  task automatic check_resp(input string what, input swrite_regs_pkg::resp_t expected,
                            input swrite_regs_pkg::resp_t actual);
    if (actual !== expected)
    begin
      $display("ERROR %s %s: expected %b, actual %b", current_test, what, expected, actual);
      resp_errors++;
    end
  endtask

  // Handshake misbehavior, reported in words
  task automatic report_protocol(input string what);
    $display("%s: %s", current_test, what);
    protocol_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Register model

  // Byte address for a word index, low bits random since the DUT ignores them
  function automatic logic [ADDR_WIDTH-1:0] make_addr(input int index);
    logic [ADDR_WIDTH-1:0] a;
    a = ADDR_WIDTH'(index << ADDR_LSB) | ADDR_WIDTH'($urandom % (1 << ADDR_LSB));
    return a;
  endfunction

  task automatic model_write(input int index, input logic [DATA_WIDTH-1:0] data,
                             input logic [NUM_BYTES-1:0] strb);
    if (index < NUM_REGS)
    begin
      for (int b = 0; b < NUM_BYTES; b++)
      begin
        if (strb[b])
          model[index][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  // Unmapped indices read back as zero
  function automatic logic [DATA_WIDTH-1:0] model_read(input int index);
    if (index < NUM_REGS)
      return model[index];
    return '0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks, all resume 1 unit after a rising edge

  task automatic step_cycle;
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic start_write(input int index, input logic [DATA_WIDTH-1:0] data,
                             input logic [NUM_BYTES-1:0] strb);
    S_AXI_AWADDR  = make_addr(index);
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
  endtask

  // Ready pulse, then drop valids and wait for the response
  task automatic wait_write_resp;
    while (!S_AXI_AWREADY)
      step_cycle();
    if (!S_AXI_WREADY)
      report_protocol("WREADY did not rise together with AWREADY");
    step_cycle();
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    while (!S_AXI_BVALID)
      step_cycle();
  endtask

  task automatic accept_write_resp;
    check_resp("bresp", swrite_regs_pkg::RESP_OKAY, S_AXI_BRESP);
    S_AXI_BREADY = 1'b1;
    step_cycle();
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic axi_write(input int index, input logic [DATA_WIDTH-1:0] data,
                           input logic [NUM_BYTES-1:0] strb);
    start_write(index, data, strb);
    wait_write_resp();
    accept_write_resp();
    model_write(index, data, strb);
  endtask

  task automatic wait_read_data(input int index);
    S_AXI_ARADDR  = make_addr(index);
    S_AXI_ARVALID = 1'b1;
    while (!S_AXI_ARREADY)
      step_cycle();
    step_cycle();
    S_AXI_ARVALID = 1'b0;
    while (!S_AXI_RVALID)
      step_cycle();
  endtask

  task automatic accept_read;
    S_AXI_RREADY = 1'b1;
    step_cycle();
    S_AXI_RREADY = 1'b0;
  endtask

  // Reads one word and checks data and response against the model
  task automatic read_check(input int index);
    wait_read_data(index);
    check_word($sformatf("rdata[%0d]", index), model_read(index), S_AXI_RDATA);
    check_resp("rresp", swrite_regs_pkg::RESP_OKAY, S_AXI_RRESP);
    accept_read();
  endtask

  task automatic check_exports;
    check_word("cmd", model[swrite_regs_pkg::REG_CMD], cmd);
    check_word("addr_0", model[swrite_regs_pkg::REG_ADDR_0], addr_0);
    check_word("addr_1", model[swrite_regs_pkg::REG_ADDR_1], addr_1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset;
    current_test = "test_reset";
    check_word("rdata after reset", '0, S_AXI_RDATA);
    check_resp("bresp", swrite_regs_pkg::RESP_OKAY, S_AXI_BRESP);
    check_resp("rresp", swrite_regs_pkg::RESP_OKAY, S_AXI_RRESP);
    check_exports();
    for (int i = 0; i < NUM_REGS; i++)
      read_check(i);
  endtask

  task automatic test_full_words;
    current_test = "test_full_words";
    for (int i = 0; i < NUM_REGS; i++)
    begin
      axi_write(i, $urandom, '1);
      read_check(i);
    end
    check_exports();
  endtask

  task automatic test_byte_strobes;
    int index;
    current_test = "test_byte_strobes";
    for (int n = 0; n < 12; n++)
    begin
      // Every third pass hits cmd so the export sees partial updates
      index = (n % 3 == 0) ? swrite_regs_pkg::REG_CMD : int'($urandom % NUM_REGS);
      axi_write(index, $urandom, NUM_BYTES'($urandom));
      read_check(index);
      check_exports();
    end
  endtask

  task automatic test_out_of_range;
    current_test = "test_out_of_range";
    axi_write(NUM_REGS, $urandom, '1);
    for (int i = 0; i < NUM_REGS; i++)
      read_check(i);
    read_check(NUM_REGS);
    check_exports();
  endtask

  task automatic test_backpressure;
    logic [DATA_WIDTH-1:0] first_data;
    logic [DATA_WIDTH-1:0] second_data;
    int                    wait_cycles;
    current_test = "test_backpressure";
    first_data  = $urandom;
    second_data = $urandom;

    // First write, response left pending
    start_write(4, first_data, '1);
    wait_write_resp();
    model_write(4, first_data, '1);

    // Second write presented while BREADY stays low
    start_write(5, second_data, '1);
    wait_cycles = 2 + ($urandom % 8);
    for (int c = 0; c < wait_cycles; c++)
    begin
      step_cycle();
      if (!S_AXI_BVALID)
        report_protocol("BVALID dropped while BREADY was low");
      if (S_AXI_AWREADY || S_AXI_WREADY)
        report_protocol("AWREADY raised while a write response was pending");
    end
    accept_write_resp();

    // Second write now goes through
    wait_write_resp();
    accept_write_resp();
    model_write(5, second_data, '1);

    // Read with RREADY held low
    wait_read_data(4);
    check_word("rdata[4]", model_read(4), S_AXI_RDATA);
    wait_cycles = 2 + ($urandom % 8);
    for (int c = 0; c < wait_cycles; c++)
    begin
      step_cycle();
      if (!S_AXI_RVALID)
        report_protocol("RVALID dropped while RREADY was low");
      check_word("rdata hold", model_read(4), S_AXI_RDATA);
    end
    accept_read();
    read_check(5);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    int unsigned seed_value;
    int          total_errors;
    seed_value      = $urandom(32'hd5a8aa77);
    word_errors     = 0;
    resp_errors     = 0;
    protocol_errors = 0;
    cycle_count     = 0;
    current_test    = "setup";
    for (int i = 0; i < NUM_REGS; i++)
      model[i] = '0;

    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;

    // Reset low for 3 cycles
    repeat (3)
      step_cycle();
    S_AXI_ARESETN = 1'b1;
    step_cycle();

    test_reset();
    test_full_words();
    test_byte_strobes();
    test_out_of_range();
    test_backpressure();

    total_errors = word_errors + resp_errors + protocol_errors;
    $display("Error counts: word %0d, response %0d, protocol %0d",
             word_errors, resp_errors, protocol_errors);
    if (total_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* verilog/axil_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite slave handshake control, one transfer in flight per direction
// Issues the address latch and register access strobes to the datapath
////////////////////////////////////////////////////////////////////////////

module axil_ctrl
(
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,

  // Write address and write data channels
  input  logic                   S_AXI_AWVALID,
  output logic                   S_AXI_AWREADY,
  input  logic                   S_AXI_WVALID,
  output logic                   S_AXI_WREADY,

  // Write response channel
  output logic                   S_AXI_BVALID,
  output swrite_regs_pkg::resp_t S_AXI_BRESP,
  input  logic                   S_AXI_BREADY,

  // Read address and read data channels
  input  logic                   S_AXI_ARVALID,
  output logic                   S_AXI_ARREADY,
  output logic                   S_AXI_RVALID,
  output swrite_regs_pkg::resp_t S_AXI_RRESP,
  input  logic                   S_AXI_RREADY,

  // Strobes to the datapath
  output logic                   aw_accept,
  output logic                   wr_en,
  output logic                   ar_accept,
  output logic                   rd_en
);

  // Data channel side of the write acceptance
  logic w_accept;

  ////////////////////////////////////////////////////////////////////////////
  // Write path

  // Wait for both channels, and hold off while a response is still owed
  assign aw_accept = ~S_AXI_AWREADY & S_AXI_AWVALID & S_AXI_WVALID & ~S_AXI_BVALID;
  assign w_accept  = ~S_AXI_WREADY & S_AXI_WVALID & S_AXI_AWVALID & ~S_AXI_BVALID;

  // Both handshakes complete in the same cycle
  assign wr_en = S_AXI_AWREADY & S_AXI_AWVALID & S_AXI_WREADY & S_AXI_WVALID;

  // Ready pulses last one cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      S_AXI_AWREADY <= 1'b0;
      S_AXI_WREADY  <= 1'b0;
    end
    else
    begin
      S_AXI_AWREADY <= aw_accept;
      S_AXI_WREADY  <= w_accept;
    end
  end

  // Response valid rises after the write, drops on BREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_BVALID <= 1'b0;
    else if (wr_en)
      S_AXI_BVALID <= 1'b1;
    else if (S_AXI_BREADY)
      S_AXI_BVALID <= 1'b0;
  end

  // No error path in this block
  assign S_AXI_BRESP = swrite_regs_pkg::RESP_OKAY;

  ////////////////////////////////////////////////////////////////////////////
  // Read path

  // New read only once the previous data was taken
  assign ar_accept = ~S_AXI_ARREADY & S_AXI_ARVALID & ~S_AXI_RVALID;

  // Address handshake, data gets registered here
  assign rd_en = S_AXI_ARREADY & S_AXI_ARVALID;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_ARREADY <= 1'b0;
    else
      S_AXI_ARREADY <= ar_accept;
  end

  // Read data valid, held until the master takes it
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_RVALID <= 1'b0;
    else if (rd_en)
      S_AXI_RVALID <= 1'b1;
    else if (S_AXI_RREADY)
      S_AXI_RVALID <= 1'b0;
  end

  assign S_AXI_RRESP = swrite_regs_pkg::RESP_OKAY;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks

  // Address and data channels are accepted together
  awready_eq_wready: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY == S_AXI_WREADY);

  // A write response is never withdrawn before BREADY
  bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

  // Same rule on the read data channel
  rvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID);

endmodule

/* verilog/swrite_read_mux.sv */
////////////////////////////////////////////////////////////////////////////
// Read side of the register block, selects a word and registers RDATA
////////////////////////////////////////////////////////////////////////////

module swrite_read_mux
#(
  parameter int DATA_WIDTH = swrite_regs_pkg::C_DATA_WIDTH,
  parameter int ADDR_WIDTH = swrite_regs_pkg::C_ADDR_WIDTH,
  parameter int NUM_REGS   = swrite_regs_pkg::C_NUM_REGS
)
(
  input  logic                           S_AXI_ACLK,
  input  logic                           S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]          S_AXI_ARADDR,
  input  logic                           ar_accept,
  input  logic                           rd_en,
  input  logic [NUM_REGS*DATA_WIDTH-1:0] regs_flat,
  output logic [DATA_WIDTH-1:0]          S_AXI_RDATA
);

  localparam int INDEX_WIDTH = ADDR_WIDTH - swrite_regs_pkg::C_ADDR_LSB;

  // Latched read word index
  logic [INDEX_WIDTH-1:0] rd_index;

  // Selected register before the output stage
  logic [DATA_WIDTH-1:0] rd_word;

  ////////////////////////////////////////////////////////////////////////////
  // Read address latch

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      rd_index <= '0;
    else if (ar_accept)
      rd_index <= S_AXI_ARADDR[ADDR_WIDTH-1:swrite_regs_pkg::C_ADDR_LSB];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word select

  // Unmapped indices read as zero
  always_comb
  begin
    rd_word = '0;
    if (rd_index < NUM_REGS)
      rd_word = regs_flat[rd_index*DATA_WIDTH +: DATA_WIDTH];
  end

  // Output register, holds while RVALID waits for RREADY
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      S_AXI_RDATA <= '0;
    else if (rd_en)
      S_AXI_RDATA <= rd_word;
  end

endmodule

/* verilog/swrite_reg_bank.sv */
////////////////////////////////////////////////////////////////////////////
// Control register storage with byte strobes for the SWRITE unpack path
// Exports the command and address words and a flat copy for readback
////////////////////////////////////////////////////////////////////////////

module swrite_reg_bank
#(
  parameter int DATA_WIDTH = swrite_regs_pkg::C_DATA_WIDTH,
  parameter int ADDR_WIDTH = swrite_regs_pkg::C_ADDR_WIDTH,
  parameter int NUM_REGS   = swrite_regs_pkg::C_NUM_REGS
)
(
  input  logic                           S_AXI_ACLK,
  input  logic                           S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]          S_AXI_AWADDR,
  input  logic [DATA_WIDTH-1:0]          S_AXI_WDATA,
  input  logic [DATA_WIDTH/8-1:0]        S_AXI_WSTRB,
  input  logic                           aw_accept,
  input  logic                           wr_en,
  output logic [NUM_REGS*DATA_WIDTH-1:0] regs_flat,
  output logic [DATA_WIDTH-1:0]          cmd,
  output logic [DATA_WIDTH-1:0]          addr_0,
  output logic [DATA_WIDTH-1:0]          addr_1
);

  // Word index taken from above the byte offset
  localparam int INDEX_WIDTH = ADDR_WIDTH - swrite_regs_pkg::C_ADDR_LSB;

  // Byte lanes per word
  localparam int NUM_BYTES = DATA_WIDTH / 8;

  // Latched write word index
  logic [INDEX_WIDTH-1:0] wr_index;

  // Index falls on an implemented register
  logic wr_hit;

  // Register storage
  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  ////////////////////////////////////////////////////////////////////////////
  // Write address latch

  // Byte offset bits are dropped here
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      wr_index <= '0;
    else if (aw_accept)
      wr_index <= S_AXI_AWADDR[ADDR_WIDTH-1:swrite_regs_pkg::C_ADDR_LSB];
  end

  // Writes to the unused top index are dropped
  assign wr_hit = (wr_index < NUM_REGS);

  ////////////////////////////////////////////////////////////////////////////
  // Byte-strobed register update

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int r = 0; r < NUM_REGS; r++)
        regs[r] <= '0;
    end
    else if (wr_en && wr_hit)
    begin
      // Only lanes with their strobe set change
      for (int b = 0; b < NUM_BYTES; b++)
      begin
        if (S_AXI_WSTRB[b])
          regs[wr_index][b*8 +: 8] <= S_AXI_WDATA[b*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Exported words

  // Index 0 sits in the low bits
  for (genvar i = 0; i < NUM_REGS; i++)
  begin : g_flat
    assign regs_flat[i*DATA_WIDTH +: DATA_WIDTH] = regs[i];
  end

  // Straight from the registers to the unpacking logic
  assign cmd    = regs[swrite_regs_pkg::REG_CMD];
  assign addr_0 = regs[swrite_regs_pkg::REG_ADDR_0];
  assign addr_1 = regs[swrite_regs_pkg::REG_ADDR_1];

  // Write strobe always follows an address acceptance one cycle earlier
  wr_after_accept: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    wr_en |-> $past(aw_accept));

endmodule

/* verilog/swrite_regs_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, register map and AXI response codes for the SWRITE
// unpack control registers, referenced by scoped name from each file
////////////////////////////////////////////////////////////////////////////

package swrite_regs_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry defaults

  // AXI4-Lite data bus width
  localparam int C_DATA_WIDTH = 32;

  // Byte address width, enough for eight 32-bit words
  localparam int C_ADDR_WIDTH = 5;

  // Implemented registers, index 7 is a hole in the map
  localparam int C_NUM_REGS = 7;

  // Low address bits that pick a byte inside a word
  localparam int C_ADDR_LSB = 2;

  // Word index width taken from the byte address
  localparam int C_INDEX_WIDTH = C_ADDR_WIDTH - C_ADDR_LSB;

  ////////////////////////////////////////////////////////////////////////////
  // Register map

  // Command word for the unpacking logic
  localparam int REG_CMD = 0;

  // Low address word
  localparam int REG_ADDR_0 = 1;

  // High address word
  localparam int REG_ADDR_1 = 2;

  // Indices 3 to 6 are plain scratch registers

  ////////////////////////////////////////////////////////////////////////////
  // Response codes

  // AXI BRESP / RRESP encoding
  typedef logic [1:0] resp_t;

  // Normal completion, the only code this block returns
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

/* verilog/swrite_unpack_top.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite control register block for the SWRITE unpacking path
// Drives cmd, addr_0 and addr_1 to the unpacker, other words are scratch
////////////////////////////////////////////////////////////////////////////

module swrite_unpack_top
#(
  parameter int DATA_WIDTH = swrite_regs_pkg::C_DATA_WIDTH,
  parameter int ADDR_WIDTH = swrite_regs_pkg::C_ADDR_WIDTH,
  parameter int NUM_REGS   = swrite_regs_pkg::C_NUM_REGS
)
(
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,

  // Write address channel
  input  logic [ADDR_WIDTH-1:0]  S_AXI_AWADDR,
  input  logic                   S_AXI_AWVALID,
  output logic                   S_AXI_AWREADY,

  // Write data channel
  input  logic [DATA_WIDTH-1:0]  S_AXI_WDATA,
  input  logic [DATA_WIDTH/8-1:0] S_AXI_WSTRB,
  input  logic                   S_AXI_WVALID,
  output logic                   S_AXI_WREADY,

  // Write response channel
  output swrite_regs_pkg::resp_t S_AXI_BRESP,
  output logic                   S_AXI_BVALID,
  input  logic                   S_AXI_BREADY,

  // Read address channel
  input  logic [ADDR_WIDTH-1:0]  S_AXI_ARADDR,
  input  logic                   S_AXI_ARVALID,
  output logic                   S_AXI_ARREADY,

  // Read data channel
  output logic [DATA_WIDTH-1:0]  S_AXI_RDATA,
  output swrite_regs_pkg::resp_t S_AXI_RRESP,
  output logic                   S_AXI_RVALID,
  input  logic                   S_AXI_RREADY,

  // Words for the unpacking logic
  output logic [DATA_WIDTH-1:0]  cmd,
  output logic [DATA_WIDTH-1:0]  addr_0,
  output logic [DATA_WIDTH-1:0]  addr_1
);

  // Handshake strobes
  logic aw_accept;
  logic wr_en;
  logic ar_accept;
  logic rd_en;

  // All registers for the read side
  logic [NUM_REGS*DATA_WIDTH-1:0] regs_flat;

  ////////////////////////////////////////////////////////////////////////////
  // Channel control

  axil_ctrl axil_ctrl_inst
  (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .aw_accept     (aw_accept),
    .wr_en         (wr_en),
    .ar_accept     (ar_accept),
    .rd_en         (rd_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register storage and readback

  swrite_reg_bank #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_REGS   (NUM_REGS)
  ) swrite_reg_bank_inst (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .aw_accept     (aw_accept),
    .wr_en         (wr_en),
    .regs_flat     (regs_flat),
    .cmd           (cmd),
    .addr_0        (addr_0),
    .addr_1        (addr_1)
  );

  swrite_read_mux #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_REGS   (NUM_REGS)
  ) swrite_read_mux_inst (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .ar_accept     (ar_accept),
    .rd_en         (rd_en),
    .regs_flat     (regs_flat),
    .S_AXI_RDATA   (S_AXI_RDATA)
  );

endmodule
